//--- lsb_addr_gen.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsb_addr_gen (
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  logic                    rdy,
    input  logic                    clr,

    input  lsu_pkg::lsb_dispatch_t  dispatch,
    output lsu_pkg::mem_req_t       mem_req
);

lsu_pkg::data_t     sum;
lsu_pkg::mem_len_t  len;
lsu_pkg::data_t     wdata;
lsu_pkg::mem_req_t  req_q;

assign sum = dispatch.base + dispatch.imm;

always_comb begin
    case (dispatch.op)
        lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: len = lsu_pkg::LEN_BYTE;
        lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: len = lsu_pkg::LEN_HALF;
        default:                                len = lsu_pkg::LEN_WORD;
    endcase
end

// spread store data over every lane it could land in
always_comb begin
    case (len)
        lsu_pkg::LEN_BYTE: wdata = {(`DATA_W / 8){dispatch.store_data[7:0]}};
        lsu_pkg::LEN_HALF: wdata = {(`DATA_W / 16){dispatch.store_data[15:0]}};
        default:           wdata = dispatch.store_data;
    endcase
end

always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
        req_q <= '0;
    end else if (clr) begin
        req_q.valid <= 1'b0;
    end else if (rdy) begin
        req_q.valid <= dispatch.valid;
        if (dispatch.valid) begin
            req_q.write   <= lsu_pkg::is_store(dispatch.op);
            req_q.len     <= len;
            req_q.addr    <= sum[`ADDR_W-1:0];    // wraps inside data memory
            req_q.wdata   <= wdata;
            req_q.rob_idx <= dispatch.rob_idx;
            req_q.op      <= dispatch.op;
        end
    end
end

always_comb begin
    mem_req       = req_q;
    mem_req.valid = req_q.valid & rdy;
end

endmodule

//--- lsb_load_align.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsb_load_align (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                rdy,
    input  logic                clr,

    input  lsu_pkg::mem_rsp_t   mem_rsp,
    output lsu_pkg::result_t    result
);

logic [7:0]         sel_b;
logic [15:0]        sel_h;
lsu_pkg::data_t     ext;
lsu_pkg::result_t   res_q;

always_comb begin
    sel_b = mem_rsp.rdata[{mem_rsp.addr_lo, 3'b000} +: 8];
    sel_h = mem_rsp.rdata[{mem_rsp.addr_lo[1], 4'b0000} +: 16];
    case (mem_rsp.op)
        lsu_pkg::LB:  ext = {{(`DATA_W - 8){sel_b[7]}}, sel_b};
        lsu_pkg::LBU: ext = {{(`DATA_W - 8){1'b0}}, sel_b};
        lsu_pkg::LH:  ext = {{(`DATA_W - 16){sel_h[15]}}, sel_h};
        lsu_pkg::LHU: ext = {{(`DATA_W - 16){1'b0}}, sel_h};
        lsu_pkg::LW:  ext = mem_rsp.rdata;
        default:      ext = '0;     // stores report zero
    endcase
end

always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
        res_q <= '0;
    end else if (clr) begin
        res_q.valid <= 1'b0;
    end else if (rdy) begin
        res_q.valid <= mem_rsp.valid;
        if (mem_rsp.valid) begin
            res_q.rob_idx <= mem_rsp.rob_idx;
            res_q.data    <= ext;
        end
    end
end

always_comb begin
    result       = res_q;
    result.valid = res_q.valid & rdy;
end

endmodule

//--- lsb_queue.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module lsb_queue (
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  logic                    rdy,
    input  logic                    clr,

    input  lsu_pkg::issue_req_t     issue,
    input  lsu_pkg::cdb_t           alu_wb,
    input  lsu_pkg::result_t        result,

    output lsu_pkg::lsb_dispatch_t  dispatch,
    output logic                    full
);

localparam int PTR_W = $clog2(`LSB_SIZE);

typedef logic [PTR_W-1:0] ptr_t;
typedef logic [PTR_W:0]   cnt_t;

typedef struct packed {
    lsu_pkg::rob_idx_t  rob_idx;
    lsu_pkg::mem_op_e   op;
    lsu_pkg::operand_t  rs1;
    lsu_pkg::operand_t  rs2;
    lsu_pkg::data_t     imm;
} entry_t;

entry_t                 ent [`LSB_SIZE];
ptr_t                   head;
ptr_t                   tail;
cnt_t                   count;
logic                   inflight;   // one memory op at a time
lsu_pkg::lsb_dispatch_t disp_q;

logic                   push;
logic                   pop;
logic                   head_ready;
entry_t                 head_ent;

// capture broadcast data if this operand waits on its tag
function automatic lsu_pkg::operand_t wake(lsu_pkg::operand_t opnd, lsu_pkg::cdb_t cdb);
    lsu_pkg::operand_t res;
    res = opnd;
    if (opnd.waiting && cdb.valid && opnd.tag == cdb.rob_idx) begin
        res.waiting = 1'b0;
        res.value   = cdb.data;
    end
    return res;
endfunction

function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(`LSB_SIZE - 1)) ? '0 : ptr + 1'b1;
endfunction

// ============================================================
// head check
// ============================================================

assign head_ent = ent[head];
assign full     = (count == cnt_t'(`LSB_SIZE));
assign push     = issue.valid && !full;

// loads ignore rs2
assign head_ready = (count != '0) && !head_ent.rs1.waiting &&
                    !(lsu_pkg::is_store(head_ent.op) && head_ent.rs2.waiting);
assign pop        = head_ready && !inflight;

// ============================================================
// entry storage and wakeup
// ============================================================

always_ff @(posedge clk_in) begin
    if (rdy) begin
        for (int i = 0; i < `LSB_SIZE; i++) begin
            ent[i].rs1 <= wake(ent[i].rs1, alu_wb);
            ent[i].rs2 <= wake(ent[i].rs2, alu_wb);
        end
        if (push) begin
            ent[tail].rob_idx <= issue.rob_idx;
            ent[tail].op      <= issue.op;
            ent[tail].rs1     <= wake(issue.rs1, alu_wb);  // same-cycle broadcast
            ent[tail].rs2     <= wake(issue.rs2, alu_wb);
            ent[tail].imm     <= issue.imm;
        end
    end
end

// ============================================================
// pointers, count and dispatch
// ============================================================

always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
        head     <= '0;
        tail     <= '0;
        count    <= '0;
        inflight <= 1'b0;
        disp_q   <= '0;
    end else if (clr) begin
        head         <= '0;
        tail         <= '0;
        count        <= '0;
        inflight     <= 1'b0;
        disp_q.valid <= 1'b0;
    end else if (rdy) begin
        if (push) begin
            tail <= next_ptr(tail);
        end
        if (pop) begin
            head <= next_ptr(head);
        end
        count <= count + cnt_t'(push) - cnt_t'(pop);

        if (pop) begin
            inflight <= 1'b1;
        end else if (result.valid) begin
            inflight <= 1'b0;   // previous op returned
        end

        disp_q.valid <= pop;
        if (pop) begin
            disp_q.rob_idx    <= head_ent.rob_idx;
            disp_q.op         <= head_ent.op;
            disp_q.base       <= head_ent.rs1.value;
            disp_q.imm        <= head_ent.imm;
            disp_q.store_data <= head_ent.rs2.value;
        end
    end
end

// strobe only counts on ready cycles
always_comb begin
    dispatch       = disp_q;
    dispatch.valid = disp_q.valid & rdy;
end

endmodule

//--- lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ============================================================
// queue and datapath sizing
// ============================================================

`define LSB_SIZE        8       // load-store buffer entries
`define ROB_IDX_W       4
`define DATA_W          32
`define ADDR_W          10      // byte address of the 1 KB data memory

// ============================================================
// memory timing
// ============================================================

// cycles from accept to done
`define MEM_LATENCY     3

`endif

//--- lsu_pkg.sv
package lsu_pkg;

`include "lsu_config.svh"

typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;
typedef logic [`DATA_W-1:0]     data_t;
typedef logic [`ADDR_W-1:0]     addr_t;
typedef logic [1:0]             mem_len_t;

localparam mem_len_t LEN_BYTE = 2'd0;
localparam mem_len_t LEN_HALF = 2'd1;
localparam mem_len_t LEN_WORD = 2'd2;

// loads first, stores from SB up
typedef enum logic [2:0] {
    LB, LH, LW, LBU, LHU, SB, SH, SW
} mem_op_e;

typedef struct packed {
    logic       waiting;    // still waiting on tag
    rob_idx_t   tag;
    data_t      value;
} operand_t;

typedef struct packed {
    logic       valid;
    rob_idx_t   rob_idx;
    mem_op_e    op;
    operand_t   rs1;        // base
    operand_t   rs2;        // store data
    data_t      imm;
} issue_req_t;

typedef struct packed {
    logic       valid;
    rob_idx_t   rob_idx;
    data_t      data;
} cdb_t;

typedef struct packed {
    logic       valid;
    rob_idx_t   rob_idx;
    mem_op_e    op;
    data_t      base;
    data_t      imm;
    data_t      store_data;
} lsb_dispatch_t;

typedef struct packed {
    logic       valid;
    logic       write;
    mem_len_t   len;
    addr_t      addr;
    data_t      wdata;
    rob_idx_t   rob_idx;
    mem_op_e    op;
} mem_req_t;

typedef struct packed {
    logic       valid;
    data_t      rdata;
    rob_idx_t   rob_idx;
    mem_op_e    op;
    logic [1:0] addr_lo;
} mem_rsp_t;

typedef struct packed {
    logic       valid;
    rob_idx_t   rob_idx;
    data_t      data;
} result_t;

function automatic logic is_store(mem_op_e op);
    return op inside {SB, SH, SW};
endfunction

endpackage

//--- lsu_top.f
+incdir+.
lsu_pkg.sv
lsb_queue.sv
lsb_addr_gen.sv
mem_ctrl.sv
lsb_load_align.sv
lsu_top.sv
tb_lsu_top.sv

//--- lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                rdy,
    input  logic                clr,

    input  lsu_pkg::issue_req_t issue,
    input  lsu_pkg::cdb_t       alu_wb,

    output lsu_pkg::result_t    result,
    output logic                full
);

lsu_pkg::lsb_dispatch_t dispatch;
lsu_pkg::mem_req_t      mem_req;
lsu_pkg::mem_rsp_t      mem_rsp;

lsb_queue u_lsb_queue (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .rdy      (rdy),
    .clr      (clr),
    .issue    (issue),
    .alu_wb   (alu_wb),
    .result   (result),     // frees the in-flight slot
    .dispatch (dispatch),
    .full     (full)
);

lsb_addr_gen u_lsb_addr_gen (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .rdy      (rdy),
    .clr      (clr),
    .dispatch (dispatch),
    .mem_req  (mem_req)
);

mem_ctrl u_mem_ctrl (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .rdy      (rdy),
    .clr      (clr),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
);

lsb_load_align u_lsb_load_align (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .rdy      (rdy),
    .clr      (clr),
    .mem_rsp  (mem_rsp),
    .result   (result)
);

endmodule

//--- mem_ctrl.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module mem_ctrl (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                rdy,
    input  logic                clr,

    input  lsu_pkg::mem_req_t   mem_req,
    output lsu_pkg::mem_rsp_t   mem_rsp
);

localparam int MEM_BYTES = 1 << `ADDR_W;
localparam int LANES     = `DATA_W / 8;
localparam int CNT_W     = $clog2(`MEM_LATENCY + 1);

typedef logic [CNT_W-1:0] cnt_t;
typedef logic [LANES-1:0] lane_t;
typedef enum logic {ST_IDLE, ST_WAIT} state_e;

logic [7:0]         mem [MEM_BYTES];
state_e             state;
cnt_t               cnt;
logic               accept;
lane_t              be;
lsu_pkg::addr_t     word_addr;
lsu_pkg::data_t     rd_word;

lsu_pkg::data_t     rsp_data;
lsu_pkg::rob_idx_t  rsp_rob;
lsu_pkg::mem_op_e   rsp_op;
logic [1:0]         rsp_lo;

assign accept    = mem_req.valid && (state == ST_IDLE);
assign word_addr = {mem_req.addr[`ADDR_W-1:2], 2'b00};

always_comb begin
    case (mem_req.len)
        lsu_pkg::LEN_BYTE: be = lane_t'(1) << mem_req.addr[1:0];
        lsu_pkg::LEN_HALF: be = lane_t'(3) << {mem_req.addr[1], 1'b0};
        default:           be = '1;
    endcase
end

always_comb begin
    for (int k = 0; k < LANES; k++) begin
        rd_word[8*k +: 8] = mem[word_addr | lsu_pkg::addr_t'(k)];
    end
end

// ============================================================
// storage and latency counter
// ============================================================

always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] <= 8'h00;
        end
        state <= ST_IDLE;
        cnt   <= '0;
    end else if (clr) begin
        state <= ST_IDLE;   // accepted stores are already in memory
    end else if (rdy) begin
        if (accept) begin
            for (int k = 0; k < LANES; k++) begin
                if (mem_req.write && be[k]) begin
                    mem[word_addr | lsu_pkg::addr_t'(k)] <= mem_req.wdata[8*k +: 8];
                end
            end
            state <= ST_WAIT;
            cnt   <= cnt_t'(`MEM_LATENCY - 1);
        end else if (state == ST_WAIT) begin
            if (cnt == '0) begin
                state <= ST_IDLE;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end
end

always_ff @(posedge clk_in) begin
    if (rdy && accept) begin
        rsp_data <= rd_word;
        rsp_rob  <= mem_req.rob_idx;
        rsp_op   <= mem_req.op;
        rsp_lo   <= mem_req.addr[1:0];
    end
end

always_comb begin
    mem_rsp.valid   = (state == ST_WAIT) && (cnt == '0) && rdy;  // done pulse
    mem_rsp.rdata   = rsp_data;
    mem_rsp.rob_idx = rsp_rob;
    mem_rsp.op      = rsp_op;
    mem_rsp.addr_lo = rsp_lo;
end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the load/store path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_lsu_top -f lsu_top.f -o sim_lsu
./obj_dir/sim_lsu | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported errors"
    exit 1
fi

//--- tb_lsu_top.sv
`timescale 1ns/100ps
`include "lsu_config.svh"

module tb_lsu_top;

localparam int QUIET_CYCLES = 2 * (`MEM_LATENCY + 3);
localparam int WAIT_LIMIT   = 400;

logic                   clk_in;
logic                   rst_n;
logic                   rdy;
logic                   clr;
lsu_pkg::issue_req_t    issue;
lsu_pkg::cdb_t          alu_wb;
lsu_pkg::result_t       result;
logic                   full;

logic [7:0]             ref_mem [1 << `ADDR_W];    // model data memory
lsu_pkg::rob_idx_t      exp_rob [$];               // expected results in program order
lsu_pkg::data_t         exp_data [$];
lsu_pkg::rob_idx_t      pend_tag [$];              // tags still to broadcast
lsu_pkg::data_t         pend_val [$];
lsu_pkg::rob_idx_t      next_rob;
lsu_pkg::rob_idx_t      next_tag;
int                     err_cnt;
int                     res_cnt;
int                     pass_tests;
int                     fail_tests;
logic                   quiet;                     // set while no result may appear
logic                   timed_out;

lsu_top u_lsu_top (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .rdy    (rdy),
    .clr    (clr),
    .issue  (issue),
    .alu_wb (alu_wb),
    .result (result),
    .full   (full)
);

initial clk_in = 1'b0;
always #4 clk_in = ~clk_in;

// ============================================================
// model and stimulus helpers
// ============================================================

function automatic logic chance(int pct);
    return $urandom_range(0, 99) < pct;
endfunction

// aligned address inside one word of the test window
function automatic lsu_pkg::addr_t lane_addr(lsu_pkg::mem_op_e op, int word);
    lsu_pkg::addr_t a;
    a = lsu_pkg::addr_t'(32'h100 + word * 4);
    if (op inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB}) begin
        a = a + lsu_pkg::addr_t'($urandom_range(0, 3));
    end else if (op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH}) begin
        a = a + lsu_pkg::addr_t'(2 * $urandom_range(0, 1));
    end
    return a;
endfunction

// replay one access on the model memory and return the extended load value
function automatic lsu_pkg::data_t model_access(lsu_pkg::mem_op_e op, lsu_pkg::addr_t a,
                                                lsu_pkg::data_t sd);
    lsu_pkg::data_t rd;
    rd = '0;
    case (op)
        lsu_pkg::SB: ref_mem[a] = sd[7:0];
        lsu_pkg::SH: begin
            ref_mem[a]         = sd[7:0];
            ref_mem[a + 10'd1] = sd[15:8];
        end
        lsu_pkg::SW: begin
            for (int k = 0; k < 4; k++) begin
                ref_mem[a + lsu_pkg::addr_t'(k)] = sd[8*k +: 8];
            end
        end
        lsu_pkg::LB:  rd = {{24{ref_mem[a][7]}}, ref_mem[a]};
        lsu_pkg::LBU: rd = {24'h0, ref_mem[a]};
        lsu_pkg::LH:  rd = {{16{ref_mem[a + 10'd1][7]}}, ref_mem[a + 10'd1], ref_mem[a]};
        lsu_pkg::LHU: rd = {16'h0, ref_mem[a + 10'd1], ref_mem[a]};
        default: begin
            for (int k = 0; k < 4; k++) begin
                rd[8*k +: 8] = ref_mem[a + lsu_pkg::addr_t'(k)];
            end
        end
    endcase
    return rd;
endfunction

task automatic drop_strobes(logic rdy_val);
    issue.valid  = 1'b0;
    alu_wb.valid = 1'b0;
    rdy          = rdy_val;
endtask

task automatic idle(int cycles, logic stall);
    repeat (cycles) begin
        @(negedge clk_in);
        drop_strobes(stall ? !chance(35) : 1'b1);
    end
endtask

// keep=0 means the op is expected to vanish (dropped or flushed)
task automatic issue_op(lsu_pkg::mem_op_e op, lsu_pkg::addr_t addr, lsu_pkg::data_t sdata,
                        logic wait_base, logic wait_data, logic bcast_now, logic keep);
    lsu_pkg::data_t imm;
    lsu_pkg::data_t base;
    int             n;
    imm  = $urandom_range(0, 4095) - 32'd2048;
    base = ($urandom << `ADDR_W) + 32'(addr) - imm;
    n    = 0;
    @(negedge clk_in);
    drop_strobes(1'b1);
    while (keep && full && !timed_out) begin
        @(negedge clk_in);
        drop_strobes(1'b1);
        n++;
        if (n > WAIT_LIMIT) begin
            $display("timeout at %0t: queue never left the full state", $time);
            timed_out = 1'b1;
            err_cnt++;
        end
    end
    issue.valid   = 1'b1;
    issue.rob_idx = next_rob;
    issue.op      = op;
    issue.imm     = imm;
    issue.rs1     = '{waiting: 1'b0, tag: '0, value: base};
    issue.rs2     = '{waiting: 1'b0, tag: '0, value: sdata};
    if (wait_base) begin
        issue.rs1 = '{waiting: 1'b1, tag: next_tag, value: $urandom};
        if (bcast_now) begin
            alu_wb = '{valid: 1'b1, rob_idx: next_tag, data: base};   // same cycle
        end else begin
            pend_tag.push_back(next_tag);
            pend_val.push_back(base);
        end
        next_tag++;
    end
    if (wait_data) begin
        issue.rs2 = '{waiting: 1'b1, tag: next_tag, value: $urandom};
        pend_tag.push_back(next_tag);
        pend_val.push_back(sdata);
        next_tag++;
    end
    if (keep) begin
        exp_rob.push_back(next_rob);
        exp_data.push_back(model_access(op, addr, sdata));
    end
    next_rob++;
endtask

// release pending tags one per cycle in random order
task automatic broadcast_all();
    int idx;
    while (pend_tag.size() != 0) begin
        @(negedge clk_in);
        drop_strobes(1'b1);
        idx = $urandom_range(0, pend_tag.size() - 1);
        alu_wb = '{valid: 1'b1, rob_idx: pend_tag[idx], data: pend_val[idx]};
        pend_tag.delete(idx);
        pend_val.delete(idx);
    end
endtask

task automatic wait_drain(logic stall);
    int n;
    n = 0;
    while (exp_rob.size() != 0 && !timed_out) begin
        @(negedge clk_in);
        drop_strobes(stall ? !chance(35) : 1'b1);
        n++;
        if (n > WAIT_LIMIT) begin
            $display("timeout at %0t: %0d results never arrived", $time, exp_rob.size());
            timed_out = 1'b1;
            err_cnt++;
        end
    end
endtask

task automatic end_test(string name, int err_before);
    if (err_cnt == err_before) begin
        pass_tests++;
        $display("%s: ok", name);
    end else begin
        fail_tests++;
        $display("%s: %0d errors", name, err_cnt - err_before);
    end
endtask

// ============================================================
// result monitor
// ============================================================

always @(posedge clk_in) begin
    if (result.valid) begin
        res_cnt++;
        assert (rdy) else begin
            $display("result pulse at %0t while the pipeline was stalled", $time);
            err_cnt++;
        end
        assert (!quiet) else begin
            $display("result at %0t after the flush, none should appear", $time);
            err_cnt++;
        end
        assert (exp_rob.size() != 0) else begin
            $display("result at %0t with no operation outstanding", $time);
            err_cnt++;
        end
        if (exp_rob.size() != 0) begin
            assert (result.rob_idx == exp_rob[0] && result.data == exp_data[0]) else begin
                $display("error at %0t: rob %0d data %h, expected rob %0d data %h",
                         $time, result.rob_idx, result.data, exp_rob[0], exp_data[0]);
                err_cnt++;
            end
            void'(exp_rob.pop_front());
            void'(exp_data.pop_front());
        end
    end
end

// ============================================================
// test sequence
// ============================================================

initial begin
    int                 e;
    int                 word;
    int                 res_before;
    int                 flush_word [`LSB_SIZE];
    logic               wb;
    lsu_pkg::mem_op_e   op;
    lsu_pkg::mem_op_e   seq [8];

    void'($urandom(32'h3e94_7766));
    rst_n      = 1'b0;
    rdy        = 1'b1;
    clr        = 1'b0;
    issue      = '0;
    alu_wb     = '0;
    ref_mem    = '{default: 8'h00};
    next_rob   = '0;
    next_tag   = '0;
    err_cnt    = 0;
    res_cnt    = 0;
    pass_tests = 0;
    fail_tests = 0;
    quiet      = 1'b0;
    timed_out  = 1'b0;
    repeat (5) @(posedge clk_in);
    @(negedge clk_in);
    rst_n = 1'b1;

    e = err_cnt;
    seq = '{lsu_pkg::SW, lsu_pkg::SH, lsu_pkg::SB, lsu_pkg::LW,
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::LB, lsu_pkg::LBU};
    repeat (6) begin
        word = $urandom_range(0, 31);
        for (int k = 0; k < 8; k++) begin
            issue_op(seq[k], lane_addr(seq[k], word), $urandom, 1'b0, 1'b0, 1'b0, 1'b1);
        end
    end
    wait_drain(1'b0);
    end_test("basic stores and loads", e);

    e = err_cnt;
    repeat (5) begin
        repeat (6) begin
            op = lsu_pkg::mem_op_e'($urandom_range(0, 7));
            wb = chance(60);
            issue_op(op, lane_addr(op, $urandom_range(0, 31)), $urandom, wb,
                     (op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW}) && chance(60),
                     wb && chance(30), 1'b1);
        end
        broadcast_all();
        wait_drain(1'b0);
    end
    end_test("operand wakeup", e);

    e = err_cnt;
    res_before = res_cnt;
    repeat (`LSB_SIZE) begin
        issue_op(lsu_pkg::LW, lane_addr(lsu_pkg::LW, $urandom_range(0, 31)), 32'h0,
                 1'b1, 1'b0, 1'b0, 1'b1);
    end
    @(negedge clk_in);
    drop_strobes(1'b1);
    assert (full) else begin
        $display("full stayed low with %0d operations queued", `LSB_SIZE);
        err_cnt++;
    end
    issue_op(lsu_pkg::LW, lane_addr(lsu_pkg::LW, 0), 32'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    broadcast_all();
    wait_drain(1'b0);
    idle(QUIET_CYCLES, 1'b0);
    assert (res_cnt - res_before == `LSB_SIZE) else begin
        $display("%0d results after the full queue drained", res_cnt - res_before);
        err_cnt++;
    end
    end_test("full", e);

    e = err_cnt;
    for (int k = 0; k < `LSB_SIZE; k++) begin
        op = lsu_pkg::mem_op_e'($urandom_range(5, 7));     // stores only
        flush_word[k] = $urandom_range(0, 31);
        wb = chance(50);
        issue_op(op, lane_addr(op, flush_word[k]), $urandom, wb, !wb || chance(50),
                 1'b0, 1'b0);
    end
    quiet = 1'b1;
    @(negedge clk_in);
    drop_strobes(1'b1);
    clr = 1'b1;
    @(negedge clk_in);
    drop_strobes(1'b1);
    clr = 1'b0;
    broadcast_all();    // flushed stores must not wake up
    idle(QUIET_CYCLES, 1'b0);
    assert (!full) else begin
        $display("full still high after the flush");
        err_cnt++;
    end
    quiet = 1'b0;
    for (int k = 0; k < `LSB_SIZE; k++) begin
        issue_op(lsu_pkg::LW, lane_addr(lsu_pkg::LW, flush_word[k]), 32'h0,
                 1'b0, 1'b0, 1'b0, 1'b1);
    end
    wait_drain(1'b0);
    end_test("flush", e);

    e = err_cnt;
    repeat (40) begin
        op = lsu_pkg::mem_op_e'($urandom_range(0, 7));
        wb = chance(30);
        issue_op(op, lane_addr(op, $urandom_range(0, 31)), $urandom, wb, 1'b0, wb, 1'b1);
        idle($urandom_range(0, 3), 1'b1);
    end
    wait_drain(1'b1);
    idle(2, 1'b0);
    end_test("stall", e);

    $display("tests ok %0d, tests with errors %0d, errors %0d", pass_tests, fail_tests,
             err_cnt);
    if (err_cnt == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule
